// ==== common/cpu_pkg.sv ====
package cpu_pkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 13;

	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [1:0] reg_sel_t;
	typedef logic [1:0] cc_t;
	typedef logic [2:0] alu_op_t;

	// Operation group, opcode bits 7:5
	localparam alu_op_t OP_LOD = 3'd0;
	localparam alu_op_t OP_EOR = 3'd1;
	localparam alu_op_t OP_AND = 3'd2;
	localparam alu_op_t OP_IOR = 3'd3;
	localparam alu_op_t OP_ADD = 3'd4;
	localparam alu_op_t OP_SUB = 3'd5;
	localparam alu_op_t OP_STR = 3'd6;
	localparam alu_op_t OP_COM = 3'd7;

	// Addressing mode, opcode bits 3:2
	localparam logic [1:0] MODE_ZERO = 2'd0;
	localparam logic [1:0] MODE_IMM = 2'd1;
	localparam logic [1:0] MODE_ABS = 2'd3;

	localparam cc_t CC_ZERO = 2'b00;
	localparam cc_t CC_POS = 2'b01;
	localparam cc_t CC_NEG = 2'b10;

	localparam byte_t OPC_HALT = 8'h40;
	localparam byte_t OPC_NOP = 8'hC0;
	localparam byte_t OPC_BCTA_BASE = 8'h1C; // Low two bits hold the condition

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		ARG_HI,
		ARG_LO,
		OPERAND,
		EXECUTE,
		WRITE_WAIT,
		HALTED
	} seq_state_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_READ,
		BUS_WRITE
	} bus_cmd_kind_t;

	typedef struct packed {
		bus_cmd_kind_t kind;
		addr_t addr;
		byte_t data; // Only meaningful for writes
	} bus_cmd_t;

	typedef struct packed {
		logic en;
		reg_sel_t sel;
		byte_t data;
		logic cc_en;
		cc_t cc;
	} reg_wr_t;

endpackage

// ==== hw/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
	input cpu_pkg::alu_op_t op,
	input cpu_pkg::byte_t a,
	input cpu_pkg::byte_t b,
	output cpu_pkg::byte_t result,
	output cpu_pkg::cc_t cc_out
);

	cpu_pkg::cc_t result_cc;
	cpu_pkg::cc_t compare_cc;

	always_comb begin
		case (op)
			cpu_pkg::OP_EOR: result = a ^ b;
			cpu_pkg::OP_AND: result = a & b;
			cpu_pkg::OP_IOR: result = a | b;
			cpu_pkg::OP_ADD: result = a + b;
			cpu_pkg::OP_SUB: result = a - b; // First operand minus second
			cpu_pkg::OP_COM: result = a; // Register keeps its value
			cpu_pkg::OP_LOD, cpu_pkg::OP_STR: result = b;
			default: result = b;
		endcase
	end

	// Sign and zero of the result
	always_comb begin
		if (result[7]) begin
			result_cc = cpu_pkg::CC_NEG;
		end else if (result != '0) begin
			result_cc = cpu_pkg::CC_POS;
		end else begin
			result_cc = cpu_pkg::CC_ZERO;
		end
	end

	always_comb begin
		if ($signed(a) > $signed(b)) begin
			compare_cc = cpu_pkg::CC_POS;
		end else if ($signed(a) < $signed(b)) begin
			compare_cc = cpu_pkg::CC_NEG;
		end else begin
			compare_cc = cpu_pkg::CC_ZERO;
		end
	end

	assign cc_out = (op == cpu_pkg::OP_COM) ? compare_cc : result_cc;

endmodule

// ==== hw/cpu_bus.sv ====
`timescale 1ns/1ps

module cpu_bus (
	input logic clk,
	input logic reset,
	input cpu_pkg::bus_cmd_t bus_cmd,
	output logic write_done,
	output cpu_pkg::addr_t adr,
	output cpu_pkg::byte_t dbus_out,
	output logic oeb,
	output logic rw,
	output logic opreq,
	output logic wrp
);

	// Write runs rw cycle, then wrp cycle, then release with write_done
	always_ff @(posedge clk) begin
		if (reset) begin
			opreq <= 1'b0;
			rw <= 1'b0;
			wrp <= 1'b0;
			write_done <= 1'b0;
		end else begin
			write_done <= 1'b0;
			if (wrp) begin
				opreq <= 1'b0;
				rw <= 1'b0;
				wrp <= 1'b0;
				write_done <= 1'b1;
			end else if (rw) begin
				wrp <= 1'b1; // Memory stores at the end of this cycle
			end else if (bus_cmd.kind == cpu_pkg::BUS_WRITE) begin
				opreq <= 1'b1;
				rw <= 1'b1;
			end else begin
				opreq <= bus_cmd.kind == cpu_pkg::BUS_READ; // One-cycle read
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_cmd.kind != cpu_pkg::BUS_IDLE) begin
			adr <= bus_cmd.addr;
		end
		if (bus_cmd.kind == cpu_pkg::BUS_WRITE) begin
			dbus_out <= bus_cmd.data;
		end
	end

	assign oeb = ~rw;

endmodule

// ==== hw/cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile (
	input logic clk,
	input logic reset,
	input cpu_pkg::reg_wr_t reg_wr,
	output cpu_pkg::byte_t regs [4],
	output cpu_pkg::cc_t cc
);

	// Register and cc writes are independent, com updates only the cc
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_wr.en) begin
			regs[reg_wr.sel] <= reg_wr.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cc <= cpu_pkg::CC_ZERO;
		end else if (reg_wr.cc_en) begin
			cc <= reg_wr.cc;
		end
	end

endmodule

// ==== hw/cpu_sequencer.sv ====
`timescale 1ns/1ps

module cpu_sequencer #(
	parameter cpu_pkg::addr_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	input cpu_pkg::byte_t dbus_in,
	input logic write_done,
	input cpu_pkg::byte_t regs [4],
	input cpu_pkg::cc_t cc,
	input cpu_pkg::byte_t alu_result,
	input cpu_pkg::cc_t alu_cc,
	output cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::byte_t alu_a,
	output cpu_pkg::byte_t alu_b,
	output cpu_pkg::bus_cmd_t bus_cmd,
	output cpu_pkg::reg_wr_t reg_wr
);

	cpu_pkg::seq_state_t state;
	cpu_pkg::seq_state_t next_state;
	cpu_pkg::addr_t pc;
	cpu_pkg::byte_t ir;
	cpu_pkg::byte_t addr_hi;
	cpu_pkg::byte_t addr_lo;
	cpu_pkg::byte_t operand;
	logic ir_ready; // Opcode captured, DECODE acts this cycle
	logic pc_step;

	cpu_pkg::alu_op_t op;
	logic [1:0] mode;
	cpu_pkg::reg_sel_t rsel;
	logic is_bcta;
	logic is_alu;
	logic is_store;
	logic taken;
	cpu_pkg::addr_t target;

	assign op = ir[7:5];
	assign mode = ir[3:2];
	assign rsel = ir[1:0];
	assign is_bcta = ir[7:2] == cpu_pkg::OPC_BCTA_BASE[7:2];
	assign is_store = op == cpu_pkg::OP_STR;
	assign is_alu = !ir[4] && ir != cpu_pkg::OPC_HALT && ir != cpu_pkg::OPC_NOP &&
		(mode == cpu_pkg::MODE_ZERO || mode == cpu_pkg::MODE_ABS ||
		(mode == cpu_pkg::MODE_IMM && !is_store)); // No immediate store
	assign taken = rsel == 2'b11 || rsel == cc; // Condition 3 means always
	assign target = {addr_hi[4:0], addr_lo}; // Bits 7:5 of high byte ignored

	// Zero mode works on r0 against rN, strz copies r0 out
	assign alu_op = op;
	assign alu_a = (mode == cpu_pkg::MODE_ZERO) ? regs[0] : regs[rsel];
	assign alu_b = (mode != cpu_pkg::MODE_ZERO) ? operand :
		(is_store ? regs[0] : regs[rsel]);

	always_comb begin
		next_state = state;
		pc_step = 1'b0;
		bus_cmd.kind = cpu_pkg::BUS_IDLE;
		bus_cmd.addr = pc;
		bus_cmd.data = regs[rsel];
		reg_wr.en = 1'b0;
		reg_wr.sel = rsel;
		reg_wr.data = alu_result;
		reg_wr.cc_en = 1'b0;
		reg_wr.cc = alu_cc;
		case (state)
			cpu_pkg::FETCH: begin
				bus_cmd.kind = cpu_pkg::BUS_READ;
				pc_step = 1'b1;
				next_state = cpu_pkg::DECODE;
			end
			cpu_pkg::DECODE: begin
				if (ir_ready) begin
					if (ir == cpu_pkg::OPC_HALT) begin
						next_state = cpu_pkg::HALTED;
					end else if (is_bcta || (is_alu && mode != cpu_pkg::MODE_ZERO)) begin
						bus_cmd.kind = cpu_pkg::BUS_READ; // First argument byte
						pc_step = 1'b1;
						next_state = (mode == cpu_pkg::MODE_IMM) ? cpu_pkg::OPERAND : cpu_pkg::ARG_HI;
					end else begin
						if (is_alu) begin // Zero mode completes here
							reg_wr.en = op != cpu_pkg::OP_COM;
							reg_wr.sel = is_store ? rsel : '0;
							reg_wr.cc_en = 1'b1;
						end
						next_state = cpu_pkg::FETCH; // nop and unsupported opcodes too
					end
				end
			end
			cpu_pkg::ARG_HI: begin
				bus_cmd.kind = cpu_pkg::BUS_READ;
				pc_step = 1'b1;
				next_state = cpu_pkg::ARG_LO;
			end
			cpu_pkg::ARG_LO: begin
				if (is_bcta || is_store) begin
					next_state = cpu_pkg::EXECUTE;
				end else begin
					bus_cmd.kind = cpu_pkg::BUS_READ; // Operand straight from low byte
					bus_cmd.addr = {addr_hi[4:0], dbus_in};
					next_state = cpu_pkg::OPERAND;
				end
			end
			cpu_pkg::OPERAND: begin
				next_state = cpu_pkg::EXECUTE;
			end
			cpu_pkg::EXECUTE: begin
				if (is_bcta) begin
					next_state = cpu_pkg::FETCH;
				end else if (is_store) begin
					bus_cmd.kind = cpu_pkg::BUS_WRITE;
					bus_cmd.addr = target;
					next_state = cpu_pkg::WRITE_WAIT;
				end else begin
					reg_wr.en = op != cpu_pkg::OP_COM; // com only touches cc
					reg_wr.cc_en = 1'b1;
					next_state = cpu_pkg::FETCH;
				end
			end
			cpu_pkg::WRITE_WAIT: begin
				if (write_done) begin
					next_state = cpu_pkg::FETCH;
				end
			end
			default: begin
				next_state = cpu_pkg::HALTED; // Held until reset
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu_pkg::FETCH;
			pc <= RESET_PC;
			ir_ready <= 1'b0;
		end else begin
			state <= next_state;
			ir_ready <= state == cpu_pkg::DECODE && !ir_ready;
			if (pc_step) begin
				pc <= pc + 1'b1;
			end else if (state == cpu_pkg::EXECUTE && is_bcta && taken) begin
				pc <= target;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == cpu_pkg::DECODE && !ir_ready) begin
			ir <= dbus_in;
		end
		if (state == cpu_pkg::ARG_HI) begin
			addr_hi <= dbus_in;
		end
		if (state == cpu_pkg::ARG_LO) begin
			addr_lo <= dbus_in;
		end
		if (state == cpu_pkg::OPERAND) begin
			operand <= dbus_in;
		end
	end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::addr_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	output cpu_pkg::addr_t adr,
	input cpu_pkg::byte_t dbus_in,
	output cpu_pkg::byte_t dbus_out,
	output logic oeb,
	output logic rw,
	output logic opreq,
	output logic wrp
);

	cpu_pkg::bus_cmd_t bus_cmd;
	cpu_pkg::reg_wr_t reg_wr;
	cpu_pkg::byte_t regs [4];
	cpu_pkg::cc_t cc;
	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::byte_t alu_a;
	cpu_pkg::byte_t alu_b;
	cpu_pkg::byte_t alu_result;
	cpu_pkg::cc_t alu_cc;
	logic write_done;

	cpu_sequencer #(
		.RESET_PC(RESET_PC)
	) cpu_sequencer_inst (
		.clk(clk),
		.reset(reset),
		.dbus_in(dbus_in),
		.write_done(write_done),
		.regs(regs),
		.cc(cc),
		.alu_result(alu_result),
		.alu_cc(alu_cc),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.bus_cmd(bus_cmd),
		.reg_wr(reg_wr)
	);

	cpu_regfile cpu_regfile_inst (
		.clk(clk),
		.reset(reset),
		.reg_wr(reg_wr),
		.regs(regs),
		.cc(cc)
	);

	cpu_alu cpu_alu_inst (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.result(alu_result),
		.cc_out(alu_cc)
	);

	cpu_bus cpu_bus_inst (
		.clk(clk),
		.reset(reset),
		.bus_cmd(bus_cmd),
		.write_done(write_done),
		.adr(adr),
		.dbus_out(dbus_out),
		.oeb(oeb),
		.rw(rw),
		.opreq(opreq),
		.wrp(wrp)
	);

endmodule

// ==== project.f ====
common/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_regfile.sv
hw/cpu_bus.sv
hw/cpu_sequencer.sv
hw/cpu_top.sv
sim/cpu_assert.sv
sim/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
	--top-module tb_cpu -Mdir obj_dir -o tb_cpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_cpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

// ==== sim/cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert (
	input logic clk,
	input logic reset,
	input logic oeb,
	input logic rw,
	input logic opreq,
	input logic wrp
);

	// Strobe only inside an active write
	wrp_in_write: assert property (@(posedge clk) disable iff (reset) wrp |-> rw && opreq)
		else $error("wrp high without rw and opreq");

	// Output enable low only inside a request
	oeb_in_request: assert property (@(posedge clk) disable iff (reset) !oeb |-> opreq)
		else $error("oeb low without opreq");

	wrp_one_cycle: assert property (@(posedge clk) disable iff (reset) wrp |=> !wrp)
		else $error("wrp held for more than one cycle");

endmodule

bind cpu_bus cpu_assert cpu_assert_inst (
	.clk(clk),
	.reset(reset),
	.oeb(oeb),
	.rw(rw),
	.opreq(opreq),
	.wrp(wrp)
);

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

	localparam cpu_pkg::addr_t RESET_PC = 13'h0040;
	localparam cpu_pkg::addr_t DATA_BASE = 13'h1000;
	localparam int HALT_QUIET = 20; // Idle cycles that count as halted
	localparam int RUN_LIMIT = 400;

	logic clk;
	logic reset;
	cpu_pkg::addr_t adr;
	cpu_pkg::byte_t dbus_in;
	cpu_pkg::byte_t dbus_out;
	logic oeb;
	logic rw;
	logic opreq;
	logic wrp;

	cpu_pkg::byte_t mem [8192];
	cpu_pkg::byte_t prog [$];
	int write_count;
	int error_count;
	int check_count;
	string test_name;
	cpu_pkg::addr_t exp_addr;
	cpu_pkg::byte_t exp_data;

	cpu_top #(
		.RESET_PC(RESET_PC)
	) cpu_top_inst (
		.clk(clk),
		.reset(reset),
		.adr(adr),
		.dbus_in(dbus_in),
		.dbus_out(dbus_out),
		.oeb(oeb),
		.rw(rw),
		.opreq(opreq),
		.wrp(wrp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Read data held for the whole request cycle
	initial begin
		dbus_in = '0;
		forever begin
			@(negedge clk);
			dbus_in = (opreq && !rw) ? mem[adr] : '0;
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			if (wrp) begin
				mem[adr] = dbus_out; // Store at the edge that ends wrp
				write_count++;
			end
		end
	end

	// Compares every store seen on the bus
	initial begin
		forever begin
			@(negedge clk);
			if (wrp) begin
				check_value({test_name, " store adr"}, int'(exp_addr), int'(adr));
				check_value({test_name, " store data"}, int'(exp_data), int'(dbus_out));
				check_value({test_name, " store oeb"}, 0, int'(oeb));
			end
		end
	end

	task automatic check_value(input string name, input int expected, input int actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic cpu_pkg::byte_t alu_ref(input cpu_pkg::alu_op_t op,
			input cpu_pkg::byte_t a, input cpu_pkg::byte_t b);
		case (op)
			cpu_pkg::OP_EOR: return a ^ b;
			cpu_pkg::OP_AND: return a & b;
			cpu_pkg::OP_IOR: return a | b;
			cpu_pkg::OP_ADD: return a + b;
			cpu_pkg::OP_SUB: return a - b;
			cpu_pkg::OP_COM: return a;
			default: return b; // lod and str pass the second operand
		endcase
	endfunction

	function automatic cpu_pkg::cc_t cc_ref(input cpu_pkg::alu_op_t op,
			input cpu_pkg::byte_t a, input cpu_pkg::byte_t b);
		int sa;
		int sb;
		cpu_pkg::byte_t r;
		sa = a[7] ? int'(a) - 256 : int'(a);
		sb = b[7] ? int'(b) - 256 : int'(b);
		r = alu_ref(op, a, b);
		if (op == cpu_pkg::OP_COM) begin
			return (sa > sb) ? cpu_pkg::CC_POS : ((sa < sb) ? cpu_pkg::CC_NEG : cpu_pkg::CC_ZERO);
		end
		return r[7] ? cpu_pkg::CC_NEG : ((r != 0) ? cpu_pkg::CC_POS : cpu_pkg::CC_ZERO);
	endfunction

	function automatic cpu_pkg::byte_t encode_op(input cpu_pkg::alu_op_t op,
			input logic [1:0] mode, input cpu_pkg::reg_sel_t r);
		return {op, 1'b0, mode, r};
	endfunction

	task automatic emit(input cpu_pkg::byte_t b);
		prog.push_back(b);
	endtask

	task automatic emit_addr(input cpu_pkg::addr_t a);
		cpu_pkg::byte_t hi;
		hi = {3'($urandom), a[12:8]}; // Top three bits are don't care
		prog.push_back(hi);
		prog.push_back(a[7:0]);
	endtask

	task automatic load_program();
		for (int i = 0; i < 8192; i++) begin
			mem[13'(i)] = 8'(i ^ (i >> 8));
		end
		foreach (prog[i]) begin
			mem[cpu_pkg::addr_t'(RESET_PC + i)] = prog[i];
		end
		prog.delete();
		write_count = 0;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic await_halt(input int stores);
		int quiet;
		int cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < HALT_QUIET && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
			quiet = opreq ? 0 : quiet + 1;
		end
		if (quiet < HALT_QUIET) begin
			error_count++;
			$display("%s: timed out waiting for the CPU to halt", test_name);
		end
		check_value({test_name, " write count"}, stores, write_count);
	endtask

	task automatic run_store_test(input string name, input cpu_pkg::addr_t dst,
			input cpu_pkg::byte_t data);
		test_name = name;
		exp_addr = dst;
		exp_data = data;
		apply_reset();
		await_halt(1);
	endtask

	initial begin
		cpu_pkg::byte_t a;
		cpu_pkg::byte_t b;
		cpu_pkg::alu_op_t op;
		cpu_pkg::addr_t dst;
		cpu_pkg::addr_t src;
		logic [1:0] cond;
		logic taken;
		int n;
		error_count = 0;
		check_count = 0;
		reset = 1'b1;
		test_name = "reset";
		void'($urandom(47));

		emit(cpu_pkg::OPC_HALT);
		load_program();
		apply_reset();
		check_value("reset opreq", 0, int'(opreq));
		check_value("reset rw", 0, int'(rw));
		check_value("reset wrp", 0, int'(wrp));
		check_value("reset oeb", 1, int'(oeb));
		n = 0;
		while (!opreq && n < 2) begin
			@(negedge clk);
			n++;
		end
		if (!opreq) begin
			error_count++;
			$display("reset: no fetch request within 2 cycles");
		end else begin
			check_value("reset fetch adr", int'(RESET_PC), int'(adr));
		end
		await_halt(0);

		for (int t = 0; t < 40; t++) begin
			a = 8'($urandom);
			b = 8'($urandom);
			op = cpu_pkg::alu_op_t'(1 + $urandom % 5); // eor through sub
			dst = cpu_pkg::addr_t'(DATA_BASE + $urandom % 256);
			emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd1));
			emit(a);
			emit(encode_op(op, cpu_pkg::MODE_IMM, 2'd1));
			emit(b);
			emit(encode_op(cpu_pkg::OP_STR, cpu_pkg::MODE_ABS, 2'd1));
			emit_addr(dst);
			emit(cpu_pkg::OPC_HALT);
			load_program();
			run_store_test($sformatf("imm op%0d trial %0d", op, t), dst, alu_ref(op, a, b));
		end

		for (int t = 0; t < 10; t++) begin
			a = 8'($urandom);
			b = 8'($urandom);
			op = cpu_pkg::alu_op_t'(1 + t % 5);
			dst = cpu_pkg::addr_t'(DATA_BASE + 13'h100 + t);
			emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd0));
			emit(a);
			emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd2));
			emit(b);
			emit(encode_op(op, cpu_pkg::MODE_ZERO, 2'd2)); // r0 against r2
			emit(encode_op(cpu_pkg::OP_STR, cpu_pkg::MODE_ABS, 2'd0));
			emit_addr(dst);
			emit(cpu_pkg::OPC_HALT);
			load_program();
			run_store_test($sformatf("zero op%0d trial %0d", op, t), dst, alu_ref(op, a, b));
		end

		a = 8'($urandom);
		dst = cpu_pkg::addr_t'(DATA_BASE + 13'h1A0);
		emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd0));
		emit(a);
		emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd2));
		emit(~a);
		emit(encode_op(cpu_pkg::OP_STR, cpu_pkg::MODE_ZERO, 2'd2)); // strz r2
		emit(encode_op(cpu_pkg::OP_STR, cpu_pkg::MODE_ABS, 2'd2));
		emit_addr(dst);
		emit(cpu_pkg::OPC_HALT);
		load_program();
		run_store_test("strz", dst, a);

		for (int t = 0; t < 10; t++) begin
			a = 8'($urandom);
			b = 8'($urandom);
			op = (t % 2 == 0) ? cpu_pkg::OP_ADD : cpu_pkg::OP_SUB;
			src = cpu_pkg::addr_t'(DATA_BASE + 13'h200 + t);
			dst = cpu_pkg::addr_t'(DATA_BASE + 13'h400 + t);
			emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_ABS, 2'd3));
			emit_addr(src);
			emit(encode_op(op, cpu_pkg::MODE_ABS, 2'd3));
			emit_addr(cpu_pkg::addr_t'(src + 13'h100));
			emit(encode_op(cpu_pkg::OP_STR, cpu_pkg::MODE_ABS, 2'd3));
			emit_addr(dst);
			emit(cpu_pkg::OPC_HALT);
			load_program();
			mem[src] = a;
			mem[cpu_pkg::addr_t'(src + 13'h100)] = b;
			run_store_test($sformatf("abs op%0d trial %0d", op, t), dst, alu_ref(op, a, b));
		end

		for (int t = 0; t < 24; t++) begin
			a = 8'($urandom);
			b = (t % 4 == 0) ? a : 8'($urandom); // Some equal pairs
			cond = 2'($urandom);
			op = (t % 3 == 2) ? cpu_pkg::alu_op_t'(1 + $urandom % 5) : cpu_pkg::OP_COM;
			dst = cpu_pkg::addr_t'(DATA_BASE + 13'h600 + t);
			taken = cond == 2'd3 || cond == cc_ref(op, a, b);
			emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd1));
			emit(a);
			emit(encode_op(op, cpu_pkg::MODE_IMM, 2'd1)); // Result cc on some trials
			emit(b);
			emit(cpu_pkg::OPC_BCTA_BASE | {6'd0, cond});
			emit_addr(cpu_pkg::addr_t'(RESET_PC + 16));
			emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd0));
			emit(8'd2); // Fall-through marker
			emit(encode_op(cpu_pkg::OP_STR, cpu_pkg::MODE_ABS, 2'd0));
			emit_addr(dst);
			emit(cpu_pkg::OPC_HALT);
			while (prog.size() < 16) begin
				emit(cpu_pkg::OPC_NOP);
			end
			emit(encode_op(cpu_pkg::OP_LOD, cpu_pkg::MODE_IMM, 2'd0));
			emit(8'd1); // Taken marker
			emit(encode_op(cpu_pkg::OP_STR, cpu_pkg::MODE_ABS, 2'd0));
			emit_addr(dst);
			emit(cpu_pkg::OPC_HALT);
			load_program();
			run_store_test($sformatf("branch op%0d cond %0d trial %0d", op, cond, t), dst,
				taken ? 8'd1 : 8'd2);
		end

		$display("tb_cpu: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
